// ==== slurm_params.svh ====
// Build constants for the slurm16 core. The opcode class sits in bits 15..12,
// except I/O, which claims every word whose top three bits are set
`ifndef SLURM_PARAMS_SVH
`define SLURM_PARAMS_SVH

`define SLURM_WORD 16
`define SLURM_NREGS 16
`define SLURM_RIDX 4
`define SLURM_RESET_PC 16'h0000

// Top nibble classes
`define SLURM_CLS_PREFIX 4'h1
`define SLURM_CLS_ALU_RR 4'h2
`define SLURM_CLS_ALU_RI 4'h3
`define SLURM_CLS_BRANCH 4'h4

// Bits 15..13 only
`define SLURM_CLS_IO 3'b111

// Class 0 sub-opcodes in bits 11..8, everything else there is a nop
`define SLURM_SUB_INC 4'h2
`define SLURM_SUB_DEC 4'h3

`endif

// ==== slurm_pkg.sv ====
// Types shared by the slurm16 pipeline stages
// Widths follow slurm_params.svh
`include "slurm_params.svh"

package slurm_pkg;

	typedef struct packed {
		logic [3:0] cls;
		logic [3:0] op;                 // ALU op, class 0 sub-opcode or branch condition
		logic [`SLURM_RIDX-1:0] dst;
		logic [`SLURM_RIDX-1:0] src;    // Doubles as imm_lo
	} alu_view_t;

	typedef struct packed {
		logic [2:0] cls;
		logic [`SLURM_RIDX-1:0] idx;    // Base register of the port address
		logic poke;                     // 1 = poke, 0 = peek
		logic [`SLURM_RIDX-1:0] dst;
		logic [3:0] imm_lo;
	} io_view_t;

	typedef union packed {
		alu_view_t alu;
		io_view_t io;
	} instr_u;

	typedef enum logic [3:0] {
		ALU_MOV, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR
	} alu_op_e;

	typedef enum logic [2:0] {
		COND_Z, COND_NZ, COND_S, COND_NS, COND_C, COND_NC, COND_ALWAYS, COND_NEVER
	} cond_e;

	typedef enum logic [2:0] {
		KIND_BUBBLE, KIND_ALU, KIND_INCDEC, KIND_BRANCH, KIND_PEEK, KIND_POKE
	} kind_e;

	typedef struct packed {
		logic z;
		logic s;
		logic c;
	} flags_t;

	typedef struct packed {
		logic valid;
		instr_u word;
	} fetch_t;

	typedef struct packed {
		logic valid;
		kind_e kind;
		alu_op_e alu_op;                // Add = inc, sub = dec for incdec entries
		logic [`SLURM_WORD-1:0] operand_a;
		logic [`SLURM_WORD-1:0] operand_b;
		logic [`SLURM_RIDX-1:0] dst;
		cond_e cond;
		logic [`SLURM_WORD-1:0] target;  // Branch target or port address
	} issue_t;

	typedef struct packed {
		logic we;
		logic [`SLURM_RIDX-1:0] addr;
		logic [`SLURM_WORD-1:0] data;
	} wb_t;

endpackage

// ==== slurm_alu.sv ====
// Combinational ALU; shifts move a by b[3:0] places
// C is carry, borrow or the last bit shifted out, and zero otherwise
`include "slurm_params.svh"

module slurm_alu (
	input  slurm_pkg::alu_op_e op,
	input  logic [`SLURM_WORD-1:0] a,
	input  logic [`SLURM_WORD-1:0] b,
	output logic [`SLURM_WORD-1:0] result,
	output slurm_pkg::flags_t flags
);
	import slurm_pkg::*;

	logic carry;

	always_comb begin
		carry = 1'b0;
		result = b;
		case (op)
			ALU_ADD: {carry, result} = {1'b0, a} + {1'b0, b};
			ALU_SUB: {carry, result} = {1'b0, a} - {1'b0, b};   // Borrow wraps into bit 16
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SHL: {carry, result} = {1'b0, a} << b[3:0];
			ALU_SHR: {result, carry} = {a, 1'b0} >> b[3:0];
			default: result = b;   // Mov and unused codes
		endcase
	end

	assign flags.z = (result == '0);
	assign flags.s = result[`SLURM_WORD-1];
	assign flags.c = carry;

endmodule

// ==== slurm_regfile.sv ====
// Sixteen general registers, cleared on reset
// Reads are combinational, so a write is seen by decode one cycle later
`include "slurm_params.svh"

module slurm_regfile (
	input  logic CLK,
	input  logic RSTb,
	input  logic [`SLURM_RIDX-1:0] rd_addr_a,
	input  logic [`SLURM_RIDX-1:0] rd_addr_b,
	output logic [`SLURM_WORD-1:0] rd_data_a,
	output logic [`SLURM_WORD-1:0] rd_data_b,
	input  slurm_pkg::wb_t wb
);

	logic [`SLURM_WORD-1:0] regs_r [`SLURM_NREGS];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < `SLURM_NREGS; i++)
				regs_r[i] <= '0;
		end else if (wb.we) begin
			regs_r[wb.addr] <= wb.data;
		end
	end

	assign rd_data_a = regs_r[rd_addr_a];
	assign rd_data_b = regs_r[rd_addr_b];

endmodule

// ==== slurm_fetch.sv ====
// Fetch with a single-word buffer; imem_valid stays low in the first cycle after reset
// A redirect drops the buffered word and any word returned in that cycle
`include "slurm_params.svh"

module slurm_fetch (
	input  logic CLK,
	input  logic RSTb,
	output logic imem_valid,
	output logic [`SLURM_WORD-1:0] imem_addr,
	input  logic imem_ready,
	input  slurm_pkg::instr_u imem_rdata,
	output slurm_pkg::fetch_t fetched,
	input  logic accept,
	input  logic redirect,
	input  logic [`SLURM_WORD-1:0] redirect_pc
);

	logic [`SLURM_WORD-1:0] pc_r;
	logic run_r;
	logic buf_valid_r;
	logic [`SLURM_WORD-1:0] buf_word_r;
	logic xfer;

	// Request whenever the buffer has room or is being emptied this cycle
	assign imem_valid = run_r && (!buf_valid_r || accept);
	assign imem_addr = pc_r;
	assign xfer = imem_valid && imem_ready;

	assign fetched.valid = buf_valid_r;
	assign fetched.word = buf_word_r;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			run_r <= 1'b0;
			pc_r <= `SLURM_RESET_PC;
			buf_valid_r <= 1'b0;
		end else begin
			run_r <= 1'b1;
			if (redirect) begin
				pc_r <= redirect_pc;
				buf_valid_r <= 1'b0;    // Wrong-path word
			end else if (xfer) begin
				pc_r <= pc_r + 1'b1;
				buf_valid_r <= 1'b1;
			end else if (accept) begin
				buf_valid_r <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (xfer)
			buf_word_r <= imem_rdata;
	end

	a_addr_stable: assert property (@(posedge CLK) disable iff (!RSTb)
		imem_valid && !imem_ready && !redirect |=> imem_addr == $past(imem_addr));

endmodule

// ==== slurm_decode.sv ====
// Decode and issue; a source register still being written by the entry in execute
// stalls for one cycle, and the prefix only applies to the very next instruction
`include "slurm_params.svh"

module slurm_decode (
	input  logic CLK,
	input  logic RSTb,
	input  slurm_pkg::fetch_t fetched,
	output logic accept,
	output logic [`SLURM_RIDX-1:0] rd_addr_a,
	output logic [`SLURM_RIDX-1:0] rd_addr_b,
	input  logic [`SLURM_WORD-1:0] rd_data_a,
	input  logic [`SLURM_WORD-1:0] rd_data_b,
	input  logic flush,
	output slurm_pkg::issue_t issue
);
	import slurm_pkg::*;

	instr_u w;
	logic [`SLURM_WORD-5:0] prefix_r;
	logic [`SLURM_WORD-1:0] imm;
	logic is_prefix;
	logic use_a;
	logic use_b;
	logic pend_we;
	logic stall;
	issue_t dec;

	assign w = fetched.word;
	assign imm = {prefix_r, w.alu.src};

	always_comb begin
		dec = '0;
		dec.alu_op = alu_op_e'(w.alu.op);
		dec.cond = cond_e'(w.alu.op[2:0]);
		dec.dst = w.alu.dst;
		dec.operand_a = rd_data_a;
		dec.operand_b = rd_data_b;
		rd_addr_a = w.alu.dst;
		rd_addr_b = w.alu.src;
		use_a = 1'b0;
		use_b = 1'b0;
		is_prefix = 1'b0;
		if (w.io.cls == `SLURM_CLS_IO) begin
			rd_addr_b = w.io.idx;
			use_a = w.io.poke;           // Poke data comes from dst
			use_b = 1'b1;
			dec.kind = w.io.poke ? KIND_POKE : KIND_PEEK;
			dec.target = rd_data_b + imm;
		end else begin
			case (w.alu.cls)
				4'h0: if (w.alu.op == `SLURM_SUB_INC || w.alu.op == `SLURM_SUB_DEC) begin
					dec.kind = KIND_INCDEC;
					dec.dst = w.alu.src;
					dec.alu_op = (w.alu.op == `SLURM_SUB_DEC) ? ALU_SUB : ALU_ADD;
					use_b = 1'b1;
				end
				`SLURM_CLS_PREFIX: is_prefix = 1'b1;
				`SLURM_CLS_ALU_RR: begin
					dec.kind = KIND_ALU;
					use_a = 1'b1;
					use_b = 1'b1;
				end
				`SLURM_CLS_ALU_RI: begin
					dec.kind = KIND_ALU;
					dec.operand_b = imm;
					use_a = 1'b1;
				end
				`SLURM_CLS_BRANCH: begin
					dec.kind = KIND_BRANCH;
					dec.target = imm;         // Absolute only
				end
				default: ;                  // Nop and dropped classes
			endcase
		end
		dec.valid = (dec.kind != KIND_BUBBLE);
	end

	// Only alu, incdec and peek entries write a register
	assign pend_we = issue.valid &&
		(issue.kind == KIND_ALU || issue.kind == KIND_INCDEC || issue.kind == KIND_PEEK);
	assign stall = fetched.valid && pend_we &&
		((use_a && rd_addr_a == issue.dst) || (use_b && rd_addr_b == issue.dst));
	assign accept = fetched.valid && !stall;

	always_ff @(posedge CLK) begin
		if (!RSTb || flush) begin
			issue <= '0;
			prefix_r <= '0;
		end else if (accept) begin
			issue <= dec;
			prefix_r <= is_prefix ? w[`SLURM_WORD-5:0] : '0;
		end else begin
			issue <= '0;                    // Bubble on stall or empty buffer
		end
	end

	a_stall_bubble: assert property (@(posedge CLK) disable iff (!RSTb)
		stall |=> !issue.valid);

endmodule

// ==== slurm_execute.sv ====
// Single-cycle execute; write-back, flags and port pulses all happen here
// Flags change only on alu entries and are seen by the next branch
`include "slurm_params.svh"

module slurm_execute (
	input  logic CLK,
	input  logic RSTb,
	input  slurm_pkg::issue_t issue,
	input  logic [`SLURM_WORD-1:0] port_in,
	output logic [`SLURM_WORD-1:0] port_addr,
	output logic [`SLURM_WORD-1:0] port_out,
	output logic port_rd,
	output logic port_wr,
	output slurm_pkg::wb_t wb,
	output logic flush,
	output logic [`SLURM_WORD-1:0] target
);
	import slurm_pkg::*;

	flags_t flags_r;
	flags_t alu_flags;
	logic [`SLURM_WORD-1:0] alu_result;
	logic [`SLURM_WORD-1:0] step;
	logic taken;

	slurm_alu u_alu (
		.op(issue.alu_op),
		.a(issue.operand_a),
		.b(issue.operand_b),
		.result(alu_result),
		.flags(alu_flags)
	);

	always_ff @(posedge CLK) begin
		if (!RSTb)
			flags_r <= '0;
		else if (issue.valid && issue.kind == KIND_ALU)
			flags_r <= alu_flags;
	end

	always_comb begin
		case (issue.cond)
			COND_Z: taken = flags_r.z;
			COND_NZ: taken = !flags_r.z;
			COND_S: taken = flags_r.s;
			COND_NS: taken = !flags_r.s;
			COND_C: taken = flags_r.c;
			COND_NC: taken = !flags_r.c;
			COND_ALWAYS: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign flush = issue.valid && issue.kind == KIND_BRANCH && taken;
	assign target = issue.target;

	assign port_addr = issue.target;
	assign port_out = issue.operand_a;
	assign port_wr = issue.valid && issue.kind == KIND_POKE;
	assign port_rd = issue.valid && issue.kind == KIND_PEEK;

	assign step = (issue.alu_op == ALU_SUB) ? issue.operand_b - 1'b1 : issue.operand_b + 1'b1;

	always_comb begin
		wb.we = 1'b0;
		wb.addr = issue.dst;
		wb.data = alu_result;
		if (issue.valid) begin
			case (issue.kind)
				KIND_ALU: wb.we = 1'b1;
				KIND_INCDEC: begin
					wb.we = 1'b1;
					wb.data = step;
				end
				KIND_PEEK: begin
					wb.we = 1'b1;
					wb.data = port_in;    // Sampled in the port_rd cycle
				end
				default: ;
			endcase
		end
	end

	a_port_excl: assert property (@(posedge CLK) disable iff (!RSTb)
		!(port_rd && port_wr));

endmodule

// ==== slurm_cpu.sv ====
// slurm16 core top: fetch, decode/issue, execute and the register file
// Everything outside is reached through the instruction bus and the port bus
`include "slurm_params.svh"

module slurm_cpu (
	input  logic CLK,
	input  logic RSTb,
	output logic imem_valid,
	output logic [`SLURM_WORD-1:0] imem_addr,
	input  logic imem_ready,
	input  logic [`SLURM_WORD-1:0] imem_rdata,
	input  logic [`SLURM_WORD-1:0] port_in,
	output logic [`SLURM_WORD-1:0] port_addr,
	output logic [`SLURM_WORD-1:0] port_out,
	output logic port_rd,
	output logic port_wr
);
	import slurm_pkg::*;

	fetch_t fetched;
	issue_t issue;
	wb_t wb;
	logic accept;
	logic flush;
	logic [`SLURM_WORD-1:0] target;
	logic [`SLURM_RIDX-1:0] rd_addr_a;
	logic [`SLURM_RIDX-1:0] rd_addr_b;
	logic [`SLURM_WORD-1:0] rd_data_a;
	logic [`SLURM_WORD-1:0] rd_data_b;

	// A taken branch is the only redirect
	slurm_fetch u_fetch (
		.CLK(CLK),
		.RSTb(RSTb),
		.imem_valid(imem_valid),
		.imem_addr(imem_addr),
		.imem_ready(imem_ready),
		.imem_rdata(imem_rdata),
		.fetched(fetched),
		.accept(accept),
		.redirect(flush),
		.redirect_pc(target)
	);

	slurm_decode u_decode (
		.CLK(CLK),
		.RSTb(RSTb),
		.fetched(fetched),
		.accept(accept),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.flush(flush),
		.issue(issue)
	);

	slurm_regfile u_regfile (
		.CLK(CLK),
		.RSTb(RSTb),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b),
		.wb(wb)
	);

	slurm_execute u_execute (
		.CLK(CLK),
		.RSTb(RSTb),
		.issue(issue),
		.port_in(port_in),
		.port_addr(port_addr),
		.port_out(port_out),
		.port_rd(port_rd),
		.port_wr(port_wr),
		.wb(wb),
		.flush(flush),
		.target(target)
	);

endmodule

// ==== tb_slurm_cpu.sv ====
// Runs each program from the table with imem_ready always high, then again with random ready
// Programs sit at addresses 0..15 and end in a branch-always to themselves
`include "slurm_params.svh"

module tb_slurm_cpu;

	localparam int n_progs = 7;
	localparam int n_rows = 2 * n_progs;       // Second half repeats the first with random ready
	localparam int prog_words = 16;
	localparam int max_pokes = 4;
	localparam int poke_timeout = 200;
	localparam int watch_cycles = 20;

	typedef struct packed {
		logic [0:prog_words-1][`SLURM_WORD-1:0] prog;
		logic rand_ready;
		logic [3:0] n_pokes;
		logic [0:max_pokes-1][2*`SLURM_WORD-1:0] pokes;    // {port address, data}
	} row_t;

	logic CLK = 1'b0;
	logic RSTb = 1'b0;
	logic imem_ready = 1'b0;
	logic imem_valid;
	logic [`SLURM_WORD-1:0] imem_addr;
	logic [`SLURM_WORD-1:0] imem_rdata;
	logic [`SLURM_WORD-1:0] port_in;
	logic [`SLURM_WORD-1:0] port_addr;
	logic [`SLURM_WORD-1:0] port_out;
	logic port_rd;
	logic port_wr;

	row_t rows [n_rows];
	string row_name [n_rows];
	row_t cur = '0;                              // Row being served by the memory model
	integer seed = 32'hddb9bfc5;
	logic [31:0] rnd;

	slurm_cpu uut (
		.CLK(CLK),
		.RSTb(RSTb),
		.imem_valid(imem_valid),
		.imem_addr(imem_addr),
		.imem_ready(imem_ready),
		.imem_rdata(imem_rdata),
		.port_in(port_in),
		.port_addr(port_addr),
		.port_out(port_out),
		.port_rd(port_rd),
		.port_wr(port_wr)
	);

	always #4 CLK = ~CLK;

	// Instruction memory answers in the same cycle, nops beyond the program
	assign imem_rdata = (imem_addr < prog_words) ? cur.prog[imem_addr[3:0]] : '0;
	// Port responder, data only while port_rd is high
	assign port_in = port_rd ? (port_addr ^ 16'h5a5a) : 16'h0000;

	always @(posedge CLK) begin
		rnd = $random(seed);
		imem_ready <= cur.rand_ready ? rnd[3] : 1'b1;
	end

	task automatic set_row(input int i, input string nm,
		input logic [0:prog_words-1][`SLURM_WORD-1:0] prog, input logic [3:0] np,
		input logic [0:max_pokes-1][2*`SLURM_WORD-1:0] pk);
		row_name[i] = nm;
		rows[i].prog = prog;
		rows[i].rand_ready = 1'b0;
		rows[i].n_pokes = np;
		rows[i].pokes = pk;
	endtask

	task automatic end_with_failure();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_word(input string test, input string what,
		input logic [`SLURM_WORD-1:0] expected, input logic [`SLURM_WORD-1:0] actual);
		if (actual !== expected) begin
			$display("Error %s %s: expected %h, actual %h", test, what, expected, actual);
			end_with_failure();
		end
	endtask

	task automatic check_count(input string test, input int unsigned expected,
		input int unsigned actual);
		if (actual != expected) begin
			$display("Error %s poke count: expected %0d, actual %0d", test, expected, actual);
			end_with_failure();
		end
	endtask

	// Sampled on the falling edge, where the port outputs are settled
	task automatic wait_for_poke(input string test, input int idx,
		output logic [`SLURM_WORD-1:0] addr, output logic [`SLURM_WORD-1:0] data);
		int n;
		logic seen;
		seen = 1'b0;
		addr = '0;
		data = '0;
		for (n = 0; n < poke_timeout && !seen; n++) begin
			@(negedge CLK);
			if (port_wr) begin
				seen = 1'b1;
				addr = port_addr;
				data = port_out;
			end
		end
		if (!seen) begin
			$display("%s: no poke %0d within %0d cycles", test, idx, poke_timeout);
			end_with_failure();
		end
	endtask

	task automatic run_row(input int r);
		logic [`SLURM_WORD-1:0] addr;
		logic [`SLURM_WORD-1:0] data;
		int k;
		int extra;
		@(posedge CLK);
		RSTb <= 1'b0;
		cur <= rows[r];
		repeat (5) @(posedge CLK);
		RSTb <= 1'b1;
		@(negedge CLK);
		// Both buses stay quiet in the first cycle after reset
		check_word(row_name[r], "imem_valid, port_rd, port_wr after reset", 16'h0000,
			{13'b0, imem_valid, port_rd, port_wr});
		for (k = 0; k < rows[r].n_pokes; k++) begin
			wait_for_poke(row_name[r], k, addr, data);
			check_word(row_name[r], $sformatf("poke %0d address", k),
				rows[r].pokes[k][31:16], addr);
			check_word(row_name[r], $sformatf("poke %0d data", k), rows[r].pokes[k][15:0], data);
		end
		extra = 0;
		for (k = 0; k < watch_cycles; k++) begin
			@(negedge CLK);
			if (port_wr) begin
				$display("%s: poke to port %h with data %h after the last expected one",
					row_name[r], port_addr, port_out);
				extra++;
			end
		end
		check_count(row_name[r], rows[r].n_pokes, rows[r].n_pokes + extra);
		$display("%s: %0d pokes checked", row_name[r], rows[r].n_pokes);
	endtask

	initial begin
		int i;
		// Reg-imm ops, two of them behind a prefix
		set_row(0, "alu_imm", {16'h3015, 16'h3117, 16'hE111, 16'h1123,
			16'h3024, 16'h322F, 16'hE122, 16'h1F0F,
			16'h3320, 16'h3421, 16'h352F, 16'hE123,
			16'h3614, 16'h3712, 16'hE114, 16'h460F},
			4'd4, {32'h0001_000C, 32'h0002_1225, 32'h0003_102E, 32'h0004_0030});
		set_row(1, "alu_reg_incdec", {16'h3019, 16'h3023, 16'h2112, 16'h2212,
			16'h2612, 16'h2512, 16'h0201, 16'h0302,
			16'h2712, 16'hE111, 16'h2031, 16'h0203,
			16'h2331, 16'h2432, 16'hE132, 16'h460F},
			4'd2, {32'h0001_0013, 32'h0002_0012, 32'h0, 32'h0});
		// Carry into BC, zero into BZ, then a BNZ that falls through
		set_row(2, "carry_zero_branch", {16'h1FFF, 16'h301F, 16'h3112, 16'h4406,
			16'hE101, 16'hE101, 16'h3027, 16'h3227,
			16'h400B, 16'hE102, 16'hE102, 16'hE113,
			16'h410E, 16'hE124, 16'hE115, 16'h460F},
			4'd3, {32'h0003_0001, 32'h0004_0000, 32'h0005_0001, 32'h0});
		set_row(3, "cond_branches", {16'h3011, 16'h3212, 16'h4205, 16'hE101,
			16'hE101, 16'h4303, 16'h4503, 16'h4703,
			16'hE111, 16'h3111, 16'h430C, 16'hE101,
			16'h440E, 16'hE101, 16'hE112, 16'h460F},
			4'd2, {32'h0001_FFFF, 32'h0002_0000, 32'h0, 32'h0});
		set_row(4, "interlock_back_to_back", {16'h3013, 16'h2111, 16'h2021, 16'h2621,
			16'h0202, 16'h2512, 16'hE111, 16'hE122,
			16'h4608, 16'h0000, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000},
			4'd2, {32'h0001_0187, 32'h0002_0181, 32'h0, 32'h0});
		set_row(5, "interlock_with_nops", {16'h3013, 16'h0000, 16'h2111, 16'h0000,
			16'h2021, 16'h0000, 16'h2621, 16'h0000,
			16'h0202, 16'h0000, 16'h2512, 16'h0000,
			16'hE111, 16'hE122, 16'h460E, 16'h0000},
			4'd2, {32'h0001_0187, 32'h0002_0181, 32'h0, 32'h0});
		// Peeks return the port address XOR 5a5a
		set_row(6, "peek_port", {16'hE025, 16'hE121, 16'h1012, 16'hE033,
			16'h3131, 16'hE132, 16'h3048, 16'hE851,
			16'hE954, 16'h4609, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000},
			4'd3, {32'h0001_5A5F, 32'h0002_5B7A, 32'h000C_5A53, 32'h0});
		for (i = 0; i < n_progs; i++) begin
			rows[n_progs + i] = rows[i];
			rows[n_progs + i].rand_ready = 1'b1;
			row_name[n_progs + i] = {row_name[i], "_rand_ready"};
		end
		for (i = 0; i < n_rows; i++)
			run_row(i);
		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
slurm_pkg.sv
slurm_alu.sv
slurm_regfile.sv
slurm_fetch.sv
slurm_decode.sv
slurm_execute.sv
slurm_cpu.sv
tb_slurm_cpu.sv

// ==== Makefile ====
# Verilator build and run for the slurm16 core testbench
# The run target fails when the simulation ends in $fatal

VERILATOR ?= verilator
FLIST ?= vlog.f
TOP ?= tb_slurm_cpu
RTL_TOP ?= slurm_cpu
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
